// File: cache_pkg.sv
package cache_pkg;

    localparam int addr_bits       = 16;                 // processor byte address width
    localparam int word_bits       = 16;                 // one data word, no byte lanes
    localparam int words_per_block = 8;                  // words fetched per fill
    localparam int offset_bits     = 3;                  // selects a word inside a block
    localparam int index_bits      = 5;                  // selects one of the cache lines
    localparam int tag_bits        = addr_bits - index_bits - offset_bits - 1;
    localparam int lines           = 1 << index_bits;    // 32 direct mapped lines
    localparam int data_words      = lines * words_per_block;  // 256 words in the data array
    localparam int mem_words       = 1 << (addr_bits - 1);     // whole word address space

    typedef logic [addr_bits-1:0]   addr_t;              // byte address
    typedef logic [word_bits-1:0]   word_t;              // data word
    typedef logic [index_bits-1:0]  index_t;             // address bits 8 to 4
    typedef logic [offset_bits-1:0] offset_t;            // address bits 3 to 1
    typedef logic [tag_bits-1:0]    tag_t;               // address bits 15 to 9

    typedef enum logic {
        fill_idle,                                       // waiting for a read miss
        fill_wait                                        // fetching the words of a block
    } fill_state_t;

    function automatic index_t line_index(input addr_t address);
        return address[offset_bits+index_bits:offset_bits+1];  // line selected by the address
    endfunction

    function automatic offset_t word_offset(input addr_t address);
        return address[offset_bits:1];                   // word inside the block, byte bit dropped
    endfunction

    function automatic tag_t line_tag(input addr_t address);
        return address[addr_bits-1:addr_bits-tag_bits];  // upper bits left over after index
    endfunction

    // before any write a memory word holds its own word address
    function automatic word_t initial_word(input addr_t address);
        return word_t'(address >> 1);                    // byte address over two
    endfunction

endpackage

// File: fill_counter.sv
module fill_counter #(
    parameter int limit = 4                              // terminal count that raises done
) (
    input  logic       clk,
    input  logic       reset,                            // synchronous clear of the count
    input  logic       start,                            // restarts the count at zero
    input  logic       step,                             // advances the count by one
    output logic [3:0] count,                            // current count value
    output logic       done                              // count has reached limit
);

    always_ff @(posedge clk) begin
        if (reset) begin
            count <= 4'd0;                               // counter starts empty after reset
        end else if (start) begin
            count <= 4'd0;                               // start wins over step
        end else if (step) begin
            count <= count + 4'd1;                       // one more cycle or word seen
        end
    end

    // done is a level and stays high for as long as the count sits on limit
    assign done = (count == 4'(limit));                  // compared against the 4 bit count

endmodule

// File: cache_fill_fsm.sv
module cache_fill_fsm #(
    parameter int mem_latency = 4                        // memory access time in cycles per word
) (
    input  logic             clk,
    input  logic             reset,
    input  logic             miss_detected,              // read request that missed the tag array
    input  cache_pkg::addr_t miss_address,               // address of the missing read
    output logic             fsm_busy,                   // used as the processor stall
    output logic             write_data_array,           // stores memory_data in the data array
    output logic             write_tag_array,            // validates the line with the fill tag
    output cache_pkg::addr_t memory_address              // word address sent to main memory
);

    cache_pkg::fill_state_t state;
    cache_pkg::fill_state_t next_state;
    cache_pkg::addr_t       fetch_address;               // word currently being fetched
    cache_pkg::addr_t       block_address;               // miss address aligned to its block
    logic                   in_wait;                     // state is fill_wait
    logic                   start_fill;                  // idle cycle that sees a miss
    logic                   word_ready;                  // latency interval has run out
    logic                   last_word;                   // word counter sits on the last word

    assign in_wait    = (state == cache_pkg::fill_wait);
    assign start_fill = (state == cache_pkg::fill_idle) && miss_detected;
    assign block_address = {miss_address[cache_pkg::addr_bits-1:cache_pkg::offset_bits+1],
                            {(cache_pkg::offset_bits+1){1'b0}}};  // first word of the block

    // the latency counter runs 0 to mem_latency-1 so each word takes mem_latency cycles
    fill_counter #(
        .limit (mem_latency - 1)
    ) latency_counter (
        .clk   (clk),
        .reset (reset),
        .start (start_fill || (in_wait && word_ready)),  // restart for every new word
        .step  (in_wait),                                // only ticks while filling
        .count (),
        .done  (word_ready)
    );

    // the word counter is on the last word while the eighth interval runs
    fill_counter #(
        .limit (cache_pkg::words_per_block - 1)
    ) word_counter (
        .clk   (clk),
        .reset (reset),
        .start (start_fill),                             // cleared once per block
        .step  (in_wait && word_ready),                  // one count per delivered word
        .count (),
        .done  (last_word)
    );

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= cache_pkg::fill_idle;               // no fill in flight after reset
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;                              // hold unless an event below
        case (state)
            cache_pkg::fill_idle: begin
                if (miss_detected) begin
                    next_state = cache_pkg::fill_wait;   // begin fetching the block
                end
            end
            cache_pkg::fill_wait: begin
                if (write_tag_array) begin
                    next_state = cache_pkg::fill_idle;   // last word and tag land together
                end
            end
            default: next_state = cache_pkg::fill_idle;
        endcase
    end

    always_ff @(posedge clk) begin
        if (start_fill) begin
            fetch_address <= block_address;              // fill always starts at word zero
        end else if (write_data_array) begin
            fetch_address <= fetch_address + cache_pkg::addr_t'(2);  // next word of the block
        end
    end

    assign write_data_array = in_wait && word_ready;     // memory has had time to answer
    assign write_tag_array  = in_wait && word_ready && last_word;  // only with the final word
    assign fsm_busy         = in_wait || miss_detected;  // stall starts in the miss cycle itself
    assign memory_address   = in_wait ? fetch_address : block_address;

endmodule

// File: tag_array.sv
module tag_array (
    input  logic             clk,
    input  logic             reset,                      // clears every valid bit
    input  cache_pkg::addr_t lookup_address,             // processor request address
    input  cache_pkg::addr_t fill_address,               // address of the block being filled
    input  logic             write_tag,                  // stores the fill tag and sets valid
    output logic             hit                         // lookup line is valid with a matching tag
);

    logic [cache_pkg::lines-1:0] valid;                  // one bit per line
    cache_pkg::tag_t             tags [cache_pkg::lines];
    cache_pkg::index_t           lookup_index;
    cache_pkg::index_t           fill_index;
    cache_pkg::tag_t             lookup_tag;

    assign lookup_index = cache_pkg::line_index(lookup_address);
    assign fill_index   = cache_pkg::line_index(fill_address);
    assign lookup_tag   = cache_pkg::line_tag(lookup_address);

    always_ff @(posedge clk) begin
        if (reset) begin
            valid <= '0;                                 // cache comes up empty
        end else if (write_tag) begin
            valid[fill_index] <= 1'b1;                   // line now holds a full block
        end
    end

    always_ff @(posedge clk) begin
        if (write_tag) begin
            tags[fill_index] <= cache_pkg::line_tag(fill_address);  // replaces any older tag
        end
    end

    // a stale tag never hits because its valid bit gates the compare
    assign hit = valid[lookup_index] && (tags[lookup_index] == lookup_tag);

endmodule

// File: data_array.sv
module data_array (
    input  logic             clk,
    input  logic             fill_write,                 // word delivered by the fill machine
    input  cache_pkg::addr_t fill_address,               // location of the delivered word
    input  cache_pkg::word_t fill_data,                  // word read from main memory
    input  logic             store_write,                // processor write that hit
    input  cache_pkg::addr_t store_address,              // location of the processor write
    input  cache_pkg::word_t store_data,                 // processor write data
    input  cache_pkg::addr_t read_address,               // processor read address
    output cache_pkg::word_t read_data                   // word at read_address, same cycle
);

    cache_pkg::word_t mem [cache_pkg::data_words];       // line index above word offset
    logic [cache_pkg::index_bits+cache_pkg::offset_bits-1:0] fill_slot;
    logic [cache_pkg::index_bits+cache_pkg::offset_bits-1:0] store_slot;
    logic [cache_pkg::index_bits+cache_pkg::offset_bits-1:0] read_slot;

    assign fill_slot  = {cache_pkg::line_index(fill_address),
                         cache_pkg::word_offset(fill_address)};
    assign store_slot = {cache_pkg::line_index(store_address),
                         cache_pkg::word_offset(store_address)};
    assign read_slot  = {cache_pkg::line_index(read_address),
                         cache_pkg::word_offset(read_address)};

    // the two ports never write together since stores wait out any stall
    always_ff @(posedge clk) begin
        if (fill_write) begin
            mem[fill_slot] <= fill_data;                 // block fill from memory
        end else if (store_write) begin
            mem[store_slot] <= store_data;               // keeps a cached word in step with memory
        end
    end

    assign read_data = mem[read_slot];                   // combinational so a hit costs no cycle

endmodule

// File: main_memory.sv
module main_memory (
    input  logic             clk,
    input  logic             write_enable,               // every processor write lands here
    input  cache_pkg::addr_t write_address,              // byte address of the write
    input  cache_pkg::word_t write_data,                 // word to store
    input  cache_pkg::addr_t read_address,               // byte address from the fill machine
    output cache_pkg::word_t read_data                   // word at read_address, no delay
);

    cache_pkg::word_t mem [cache_pkg::mem_words];        // one entry per word address
    logic [cache_pkg::addr_bits-2:0] write_word;         // byte bit dropped
    logic [cache_pkg::addr_bits-2:0] read_word;

    assign write_word = write_address[cache_pkg::addr_bits-1:1];
    assign read_word  = read_address[cache_pkg::addr_bits-1:1];

    // every word starts out holding its own word address
    initial begin
        for (int i = 0; i < cache_pkg::mem_words; i++) begin
            mem[i] = cache_pkg::initial_word(cache_pkg::addr_t'(i * 2));  // byte address of word i
        end
    end

    always_ff @(posedge clk) begin
        if (write_enable) begin
            mem[write_word] <= write_data;               // write through from the processor
        end
    end

    // the access time is modelled by the fill machine so the read itself is immediate
    assign read_data = mem[read_word];

endmodule

// File: cache_top.sv
module cache_top #(
    parameter int mem_latency = 4                        // cycles the memory needs per word
) (
    input  logic             clk,
    input  logic             reset,                      // synchronous, active high
    input  logic             access_read,                // read request level
    input  logic             access_write,               // write request level
    input  cache_pkg::addr_t address,                    // byte address of the request
    input  cache_pkg::word_t write_data,                 // data for a write request
    output cache_pkg::word_t read_data,                  // valid when stall is low
    output logic             stall                       // hold the request while high
);

    logic             hit;                               // request address is cached
    logic             miss_detected;                     // read that must wait for a fill
    logic             fsm_busy;
    logic             write_data_array;
    logic             write_tag_array;
    cache_pkg::addr_t memory_address;                    // word the fill machine is fetching
    cache_pkg::word_t memory_data;                       // memory answer for that word

    assign miss_detected = access_read && !hit;          // only reads allocate
    assign stall         = fsm_busy;                     // high from the miss cycle to the tag write

    cache_fill_fsm #(
        .mem_latency (mem_latency)
    ) u_fill_fsm (
        .clk              (clk),
        .reset            (reset),
        .miss_detected    (miss_detected),
        .miss_address     (address),
        .fsm_busy         (fsm_busy),
        .write_data_array (write_data_array),
        .write_tag_array  (write_tag_array),
        .memory_address   (memory_address)
    );

    tag_array u_tag_array (
        .clk            (clk),
        .reset          (reset),
        .lookup_address (address),
        .fill_address   (memory_address),                // tag bits match the miss address
        .write_tag      (write_tag_array),
        .hit            (hit)
    );

    data_array u_data_array (
        .clk           (clk),
        .fill_write    (write_data_array),
        .fill_address  (memory_address),
        .fill_data     (memory_data),
        .store_write   (access_write && hit),            // a write miss does not allocate
        .store_address (address),
        .store_data    (write_data),
        .read_address  (address),
        .read_data     (read_data)
    );

    main_memory u_main_memory (
        .clk           (clk),
        .write_enable  (access_write),                   // write through on hit and miss
        .write_address (address),
        .write_data    (write_data),
        .read_address  (memory_address),
        .read_data     (memory_data)
    );

endmodule

// File: cache_checker.sv
module cache_checker (
    input logic             clk,
    input logic             reset,
    input logic             miss_detected,               // read request that missed
    input cache_pkg::addr_t miss_address,                // held stable for the whole fill
    input logic             in_wait,                     // fill machine is fetching a block
    input logic             fsm_busy,                    // stall seen by the processor
    input logic             write_data_array,
    input logic             write_tag_array,
    input cache_pkg::addr_t memory_address               // word being fetched
);
    timeunit 1ns;
    timeprecision 1ps;

    // the tag only lands together with the last word of the block
    tag_with_data: assert property (@(posedge clk) disable iff (reset)
        write_tag_array |-> (write_data_array && (memory_address[3:1] == 3'd7)))
        else $error("tag write not paired with the last word of the block");

    fetch_aligned: assert property (@(posedge clk) disable iff (reset)
        in_wait |-> ((memory_address[0] == 1'b0)         // words are 2 bytes apart
                     && (memory_address[15:4] == miss_address[15:4])))  // never leaves the block
        else $error("fill address is not a word of the missing block");

    miss_enters_wait: assert property (@(posedge clk) disable iff (reset)
        (miss_detected && !in_wait) |=> in_wait)
        else $error("miss did not start a fill");

    // busy holds from the miss cycle until the cycle of the tag write
    busy_until_tag: assert property (@(posedge clk) disable iff (reset)
        (fsm_busy && !write_tag_array) |=> fsm_busy)
        else $error("stall dropped before the tag write");

    // an idle cycle without a miss keeps the next cycle free of array writes
    idle_no_writes: assert property (@(posedge clk) disable iff (reset)
        (!in_wait && !miss_detected) |=> (!write_data_array && !write_tag_array))
        else $error("array write enable raised while idle");

endmodule

bind cache_fill_fsm cache_checker u_fill_checker (
    .clk              (clk),
    .reset            (reset),
    .miss_detected    (miss_detected),
    .miss_address     (miss_address),
    .in_wait          (in_wait),                         // internal state decode of the fsm
    .fsm_busy         (fsm_busy),
    .write_data_array (write_data_array),
    .write_tag_array  (write_tag_array),
    .memory_address   (memory_address)
);

// File: cache_tb.sv
module cache_tb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int mem_latency = 4;                      // cycles per fetched word
    localparam int block_words = 8;                      // words per cache block
    localparam int miss_stall  = block_words * mem_latency + 1;  // miss cycle plus the fill

    logic        clk = 1'b0;
    logic        reset;
    logic        access_read;
    logic        access_write;
    logic [15:0] address;
    logic [15:0] write_data;
    logic [15:0] read_data;
    logic        stall;

    string       kinds [$];                              // R, W or Z per case
    logic [15:0] addrs [$];
    logic [15:0] datas [$];
    int          line_numbers [$];                       // file line of each case
    logic        cases_loaded = 1'b0;

    logic [15:0] memory_mirror [int];                    // only words written so far
    logic        model_valid [32];                       // expected valid bit per line
    logic [6:0]  model_tag [32];                         // expected tag per line

    cache_top #(
        .mem_latency (mem_latency)
    ) u_dut (
        .clk          (clk),
        .reset        (reset),
        .access_read  (access_read),
        .access_write (access_write),
        .address      (address),
        .write_data   (write_data),
        .read_data    (read_data),
        .stall        (stall)
    );

    always #5 clk = ~clk;                                // 10 ns period

    task automatic check(input string name, input logic [31:0] expected,
                         input logic [31:0] actual);
        if (expected !== actual) begin
            $display("ERROR %s expected %h actual %h", name, expected, actual);
            $display("RESULT: FAIL");
            $fatal(1, "value mismatch");
        end
    endtask

    // untouched words hold their own word address
    function automatic logic [15:0] expected_word(input logic [15:0] byte_address);
        if (memory_mirror.exists(int'(byte_address[15:1]))) begin
            return memory_mirror[int'(byte_address[15:1])];
        end
        return byte_address >> 1;
    endfunction

    function automatic logic is_cached(input logic [15:0] byte_address);
        return model_valid[byte_address[8:4]] && (model_tag[byte_address[8:4]] == byte_address[15:9]);
    endfunction

    task automatic load_cases();
        int          fd;
        int          got;
        int          line_no;
        string       text;
        string       kind_text;
        logic [15:0] a;
        logic [15:0] d;
        line_no = 0;
        fd = $fopen("cache_cases.txt", "r");
        if (fd == 0) begin
            $display("could not open the cases file cache_cases.txt");
            $display("RESULT: FAIL");
            $fatal(1, "missing cases file");
        end
        while (!$feof(fd)) begin
            got = $fgets(text, fd);
            line_no++;
            if (got > 0 && text.len() > 1 && text[0] != "#") begin  // skips comments and blanks
                got = $sscanf(text, "%s %h %h", kind_text, a, d);
                if (got == 3) begin
                    kinds.push_back(kind_text);
                    addrs.push_back(a);
                    datas.push_back(d);
                    line_numbers.push_back(line_no);
                end
            end
        end
        $fclose(fd);
    endtask

    task automatic apply_reset();
        @(posedge clk);
        #1;
        access_read  = 1'b0;
        access_write = 1'b0;
        reset        = 1'b1;
        repeat (3) @(posedge clk);
        #1 reset = 1'b0;
        for (int i = 0; i < 32; i++) begin
            model_valid[i] = 1'b0;                       // every line is empty again
        end
    endtask

    task automatic read_word(input string name, input logic [15:0] a, input logic [15:0] d);
        int stall_cycles;
        int expected_stall;
        expected_stall = is_cached(a) ? 0 : miss_stall;
        @(posedge clk);
        #1;
        access_read  = 1'b1;
        access_write = 1'b0;
        address      = a;
        write_data   = 16'h0000;
        @(negedge clk);
        stall_cycles = 0;
        while (stall) begin                              // the watchdog bounds this loop
            stall_cycles++;
            @(negedge clk);
        end
        check({name, " stall cycles"}, 32'(expected_stall), 32'(stall_cycles));
        check({name, " file vs mirror"}, 32'(expected_word(a)), 32'(d));
        check(name, 32'(d), 32'(read_data));
        model_valid[a[8:4]] = 1'b1;                      // the block is now resident
        model_tag[a[8:4]]   = a[15:9];
    endtask

    task automatic write_word(input string name, input logic [15:0] a, input logic [15:0] d);
        @(posedge clk);
        #1;
        access_read  = 1'b0;
        access_write = 1'b1;
        address      = a;
        write_data   = d;
        @(negedge clk);
        check({name, " stall"}, 32'(0), 32'(stall));     // writes never stall
        memory_mirror[int'(a[15:1])] = d;                // lands at the next rising edge
    endtask

    initial begin
        string name;
        reset        = 1'b1;
        access_read  = 1'b0;
        access_write = 1'b0;
        address      = 16'h0000;
        write_data   = 16'h0000;
        for (int i = 0; i < 32; i++) begin
            model_valid[i] = 1'b0;
            model_tag[i]   = 7'd0;
        end
        load_cases();
        cases_loaded = 1'b1;
        repeat (3) @(posedge clk);
        #1 reset = 1'b0;
        for (int i = 0; i < kinds.size(); i++) begin
            name = $sformatf("case%0d", line_numbers[i]);
            if (kinds[i] == "R") begin
                read_word(name, addrs[i], datas[i]);
            end else if (kinds[i] == "W") begin
                write_word(name, addrs[i], datas[i]);
            end else if (kinds[i] == "Z") begin
                apply_reset();
            end else begin
                $display("%s has an unknown operation kind %s", name, kinds[i]);
                $display("RESULT: FAIL");
                $fatal(1, "bad cases file");
            end
        end
        @(posedge clk);
        #1;
        access_read  = 1'b0;
        access_write = 1'b0;                             // last write retires on this edge
        @(posedge clk);
        $display("RESULT: PASS");
        $finish;
    end

    // a case never takes more than 40 cycles, a miss is 33 of them
    initial begin
        int timeout_ns;
        wait (cases_loaded);
        timeout_ns = (kinds.size() * 40 + 100) * 10;
        #(timeout_ns);
        $display("the cache stalled without finishing all cases");
        $display("RESULT: FAIL");
        $fatal(1, "timeout");
    end

endmodule

// File: cache_cases.txt
# kind (R read, W write, Z reset), byte address in hex, data in hex
# R data is the expected read value, W data is the value written, Z ignores both
R 0100 0080
R 0102 0081
R 0104 0082
R 0106 0083
R 0108 0084
R 010a 0085
R 010c 0086
R 010e 0087
W 0104 beef
R 0104 beef
W 010e 1234
R 010e 1234
R 0106 0083
W 2040 cafe
W 2046 0bad
R 2040 cafe
R 2046 0bad
R 2042 1021
R 204e 1027
R 0300 0180
R 0302 0181
R 0104 beef
R 010e 1234
R a100 5080
R a10e 5087
R 0100 0080
W 0300 5a5a
R 0100 0080
R 0300 5a5a
R 0010 0008
R 001e 000f
W 0018 0042
R 0018 0042
R fffe 7fff
R fff0 7ff8
Z 0000 0000
R 0102 0081
R 0018 0042
R 2046 0bad
R fffe 7fff
R fffa 7ffd
W 2044 0f0f
R 2044 0f0f
R 0300 5a5a
R 0102 0081
R 8000 4000
R 8008 4004
W 8008 1111
R 8008 1111
W 8200 2222
R 8200 2222
R 8008 1111
R 820e 4107
R 0010 0008

// File: verilog.f
cache_pkg.sv
fill_counter.sv
cache_fill_fsm.sv
tag_array.sv
data_array.sv
main_memory.sv
cache_top.sv
cache_checker.sv
cache_tb.sv

// File: run.sh
#!/bin/sh
# build the testbench with Verilator, run it, and look for the pass line
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -f verilog.f --top-module cache_tb -o cache_sim &&
./obj_dir/cache_sim 2>&1 | tee /dev/stderr | grep -q "^RESULT: PASS$" &&
echo "simulation passed" ||
{ echo "simulation failed"; exit 1; }
